// ==== design/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// operand and shift widths
`define XLEN 32
`define SHAMT_W 5

// long op latencies
`define DIV_STEPS 32
`define MUL_STAGES 2
`define CNT_W 6

`endif

// ==== design/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	typedef enum logic [4:0] {
		ADD,
		SUB,
		SLL,
		SRL,
		SRA,
		OR,
		AND,
		XOR,
		SLT,
		SLTU,
		MUL,
		MULH,
		MULHSU,
		MULHU,
		DIV,
		DIVU,
		REM,
		REMU,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU
	} alu_op_e;

	typedef enum logic [1:0] {IDLE, MUL_RUN, DIV_INIT, DIV_RUN} seq_state_e;

endpackage

`default_nettype wire

// ==== design/alu_step_if.sv ====
`default_nettype none
`include "alu_cfg.svh"

interface alu_step_if;
	import alu_pkg::*;

	logic [`MUL_STAGES-1:0] mul_stage;	// bit 0 loads stage 1, bit 1 loads stage 2
	logic div_init;
	logic div_advance;
	logic div_last;
	logic res_load;
	alu_op_e op;	// held for the whole operation

	modport seq (output mul_stage, div_init, div_advance, div_last, res_load, op);
	modport core (input op, res_load);
	modport div (input op, div_init, div_advance, div_last);
	modport mul (input op, mul_stage);

endinterface

`default_nettype wire

// ==== design/alu_sequencer.sv ====
`default_nettype none
`include "alu_cfg.svh"

module alu_sequencer (
	input wire clk,
	input wire reset,
	input wire start,
	input var alu_pkg::alu_op_e op_in,
	alu_step_if.seq step,
	output logic load,
	output logic [`CNT_W-1:0] load_value,
	input wire last,
	output logic busy,
	output logic done
);
	import alu_pkg::*;

	localparam logic [`CNT_W-1:0] MUL_CNT = `MUL_STAGES;
	localparam logic [`CNT_W-1:0] DIV_CNT = `DIV_STEPS;

	seq_state_e state_q, state_d, cur;
	alu_op_e op_q;
	logic busy_q, done_q, fin_q, fin_d;
	logic accept;

	function automatic seq_state_e path_of(alu_op_e o);
		if (o inside {MUL, MULH, MULHSU, MULHU})
			return MUL_RUN;
		if (o inside {DIV, DIVU, REM, REMU})
			return DIV_INIT;
		return IDLE;
	endfunction

	assign accept = start & ~busy_q;
	assign cur = accept ? path_of(op_in) : state_q;	// start cycle acts on the new path
	assign step.op = busy_q ? op_q : op_in;

	////////////////////////////////////////
	// step controls and next state

	always_comb begin
		step.mul_stage = '0;
		step.div_init = 1'b0;
		step.div_advance = 1'b0;
		step.div_last = 1'b0;
		step.res_load = 1'b0;
		load = 1'b0;
		load_value = '0;
		state_d = state_q;
		fin_d = 1'b0;
		case (cur)
			IDLE: begin
				step.res_load = accept | fin_q;	// fast op, or divide wrap-up
				state_d = IDLE;
			end
			MUL_RUN: begin
				if (accept) begin
					step.mul_stage = 2'b01;
					load = 1'b1;
					load_value = MUL_CNT;
					state_d = MUL_RUN;
				end else begin
					step.mul_stage = last ? 2'b00 : 2'b10;
					step.res_load = last;
					if (last)
						state_d = IDLE;
				end
			end
			DIV_INIT: begin
				step.div_init = 1'b1;
				load = 1'b1;
				load_value = DIV_CNT;
				state_d = DIV_RUN;
			end
			DIV_RUN: begin
				step.div_advance = 1'b1;
				step.div_last = last;
				if (last) begin
					state_d = IDLE;
					fin_d = 1'b1;	// quotient settles one edge later
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			busy_q <= 1'b0;
			done_q <= 1'b0;
			fin_q <= 1'b0;
		end else begin
			state_q <= state_d;
			fin_q <= fin_d;
			done_q <= step.res_load;
			if (accept)
				busy_q <= 1'b1;
			else if (done_q)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			op_q <= op_in;
	end

	assign busy = busy_q;
	assign done = done_q;

	a_no_done_on_accept: assert property (@(posedge clk) disable iff (reset)
		(start && !busy) |-> !done);
	a_adv_in_run: assert property (@(posedge clk) disable iff (reset)
		step.div_advance |-> state_q == DIV_RUN);

endmodule

`default_nettype wire

// ==== design/step_counter.sv ====
`default_nettype none
`include "alu_cfg.svh"

module step_counter (
	input wire clk,
	input wire reset,
	input wire load,
	input wire [`CNT_W-1:0] load_value,
	output logic last
);

	localparam logic [`CNT_W-1:0] ONE = 1;

	logic [`CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (load)
			count <= load_value;
		else if (count != '0)
			count <= count - ONE;	// parks at zero
	end

	assign last = (count == ONE);

	a_load_idle: assert property (@(posedge clk) disable iff (reset)
		load |-> count == '0);

endmodule

`default_nettype wire

// ==== design/long_div.sv ====
`default_nettype none
`include "alu_cfg.svh"

module long_div (
	input wire clk,
	alu_step_if.div step,
	input wire [`XLEN-1:0] dividend,
	input wire [`XLEN-1:0] divisor,
	output logic [`XLEN-1:0] quot,
	output logic [`XLEN-1:0] remd
);
	import alu_pkg::*;

	localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

	logic is_signed;
	logic [`XLEN-1:0] a_abs, b_abs, dvs_q;
	logic neg_q, neg_r, div_zero, ovf;
	logic [`XLEN:0] r_shift, r_diff;
	logic ge;
	logic [`XLEN-1:0] q_next, r_next;

	assign is_signed = (step.op == DIV) || (step.op == REM);
	assign a_abs = (is_signed && dividend[`XLEN-1]) ? -dividend : dividend;
	assign b_abs = (is_signed && divisor[`XLEN-1]) ? -divisor : divisor;

	////////////////////////////////////////
	// one restoring step

	always_comb begin
		r_shift = {remd, quot[`XLEN-1]};
		r_diff = r_shift - {1'b0, dvs_q};
		ge = (r_shift >= {1'b0, dvs_q});
		r_next = ge ? r_diff[`XLEN-1:0] : r_shift[`XLEN-1:0];
		q_next = {quot[`XLEN-2:0], ge};
	end

	always_ff @(posedge clk) begin
		if (step.div_init) begin
			quot <= a_abs;	// shifts out into the remainder
			remd <= '0;
			dvs_q <= b_abs;
			neg_q <= is_signed & (dividend[`XLEN-1] ^ divisor[`XLEN-1]);
			neg_r <= is_signed & dividend[`XLEN-1];
			div_zero <= (divisor == '0);
			ovf <= is_signed && (dividend == MOST_NEG) && (divisor == '1);
		end else if (step.div_advance) begin
			if (step.div_last) begin
				if (div_zero) begin
					quot <= '1;
					remd <= dividend;
				end else if (ovf) begin
					quot <= dividend;
					remd <= '0;
				end else begin
					quot <= neg_q ? -q_next : q_next;
					remd <= neg_r ? -r_next : r_next;	// remainder follows dividend sign
				end
			end else begin
				quot <= q_next;
				remd <= r_next;
			end
		end
	end

	a_init_alone: assert property (@(posedge clk)
		!(step.div_advance && step.div_init));

endmodule

`default_nettype wire

// ==== design/mul_pipe.sv ====
`default_nettype none
`include "alu_cfg.svh"

module mul_pipe (
	input wire clk,
	alu_step_if.mul step,
	input wire [`XLEN-1:0] ain,
	input wire [`XLEN-1:0] bin,
	output logic [2*`XLEN-1:0] prod
);
	import alu_pkg::*;

	logic a_sx, b_sx;
	logic signed [`XLEN:0] a_ext, b_ext;
	logic signed [2*`XLEN+1:0] full;

	// mulhsu keeps b unsigned
	assign a_sx = step.op inside {MUL, MULH, MULHSU};
	assign b_sx = step.op inside {MUL, MULH};

	////////////////////////////////////////
	// stage 1, operand capture

	always_ff @(posedge clk) begin
		if (step.mul_stage[0]) begin
			a_ext <= {a_sx & ain[`XLEN-1], ain};
			b_ext <= {b_sx & bin[`XLEN-1], bin};
		end
	end

	assign full = a_ext * b_ext;	// 33x33 signed covers all three kinds

	////////////////////////////////////////
	// stage 2, product

	always_ff @(posedge clk) begin
		if (step.mul_stage[1])
			prod <= full[2*`XLEN-1:0];
	end

endmodule

`default_nettype wire

// ==== design/barrel_shifter.sv ====
`default_nettype none
`include "alu_cfg.svh"

module barrel_shifter #(
	parameter int WIDTH = `XLEN
) (
	input wire [WIDTH-1:0] d_in,
	input wire [$clog2(WIDTH)-1:0] shamt,
	input wire arith,
	input wire right,
	output logic [WIDTH-1:0] d_out
);

	localparam int SW = $clog2(WIDTH);

	logic [WIDTH-1:0] d_rev, out_rev;
	logic [WIDTH-1:0] stage [SW+1];
	logic fill;

	// left shifts run through the right shifter bit-reversed
	for (genvar i = 0; i < WIDTH; i++) begin : g_rev
		assign d_rev[i] = d_in[WIDTH-1-i];
		assign out_rev[i] = stage[SW][WIDTH-1-i];
	end

	assign fill = arith & right & d_in[WIDTH-1];
	assign stage[0] = right ? d_in : d_rev;

	for (genvar s = 0; s < SW; s++) begin : g_stage
		assign stage[s+1] = shamt[s] ? {{(2**s){fill}}, stage[s][WIDTH-1:2**s]} : stage[s];
	end

	assign d_out = right ? stage[SW] : out_rev;

endmodule

`default_nettype wire

// ==== design/alu_core.sv ====
`default_nettype none
`include "alu_cfg.svh"

module alu_core (
	input wire clk,
	input wire reset,
	alu_step_if.core step,
	input wire [`XLEN-1:0] a,
	input wire [`XLEN-1:0] b,
	input wire [`XLEN-1:0] quot,
	input wire [`XLEN-1:0] remd,
	input wire [2*`XLEN-1:0] prod,
	output logic [`XLEN-1:0] result,
	output logic branch_taken
);
	import alu_pkg::*;

	logic sub_like, uns;
	logic [`XLEN:0] add_ans;
	logic zero, lt;
	logic [`XLEN-1:0] log_ans, sft_ans, res_d;
	logic br_d;

	////////////////////////////////////////
	// shared 33-bit adder

	assign sub_like = step.op inside {SUB, SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};
	assign uns = step.op inside {SLTU, BLTU, BGEU};
	assign add_ans = {~uns & a[`XLEN-1], a}
		+ ({(`XLEN+1){sub_like}} ^ {~uns & b[`XLEN-1], b})
		+ {{`XLEN{1'b0}}, sub_like};
	assign zero = (add_ans[`XLEN-1:0] == '0);
	assign lt = add_ans[`XLEN];	// sign of the extended difference

	assign log_ans = (step.op == AND) ? (a & b) : (step.op == OR) ? (a | b) : (a ^ b);

	barrel_shifter #(.WIDTH(`XLEN)) u_shift (
		.d_in(a),
		.shamt(b[`SHAMT_W-1:0]),
		.arith(step.op == SRA),
		.right((step.op == SRL) || (step.op == SRA)),
		.d_out(sft_ans)
	);

	always_comb begin
		br_d = 1'b0;
		case (step.op)
			ADD, SUB: res_d = add_ans[`XLEN-1:0];
			SLL, SRL, SRA: res_d = sft_ans;
			OR, AND, XOR: res_d = log_ans;
			SLT, SLTU: res_d = {{(`XLEN-1){1'b0}}, lt};
			MUL: res_d = prod[`XLEN-1:0];
			MULH, MULHSU, MULHU: res_d = prod[2*`XLEN-1:`XLEN];
			DIV, DIVU: res_d = quot;
			REM, REMU: res_d = remd;
			default: begin
				res_d = add_ans[`XLEN-1:0];	// branches report a - b
				case (step.op)
					BEQ: br_d = zero;
					BNE: br_d = ~zero;
					BLT, BLTU: br_d = lt;
					default: br_d = ~lt;
				endcase
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			branch_taken <= 1'b0;
		end else if (step.res_load) begin
			result <= res_d;
			branch_taken <= br_d;
		end
	end

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`default_nettype none
`include "alu_cfg.svh"

module exec_unit (
	input wire clk,
	input wire reset,
	input wire start,
	input var alu_pkg::alu_op_e op,
	input wire [`XLEN-1:0] a,
	input wire [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result,
	output logic branch_taken,
	output logic busy,
	output logic done
);

	logic load, last;
	logic [`CNT_W-1:0] load_value;
	logic [`XLEN-1:0] quot, remd;
	logic [2*`XLEN-1:0] prod;

	alu_step_if u_step ();

	alu_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op_in(op),
		.step(u_step.seq),
		.load(load),
		.load_value(load_value),
		.last(last),
		.busy(busy),
		.done(done)
	);

	step_counter u_cnt (
		.clk(clk),
		.reset(reset),
		.load(load),
		.load_value(load_value),
		.last(last)
	);

	long_div u_div (
		.clk(clk),
		.step(u_step.div),
		.dividend(a),
		.divisor(b),
		.quot(quot),
		.remd(remd)
	);

	mul_pipe u_mul (
		.clk(clk),
		.step(u_step.mul),
		.ain(a),
		.bin(b),
		.prod(prod)
	);

	alu_core u_core (
		.clk(clk),
		.reset(reset),
		.step(u_step.core),
		.a(a),
		.b(b),
		.quot(quot),
		.remd(remd),
		.prod(prod),
		.result(result),
		.branch_taken(branch_taken)
	);

endmodule

`default_nettype wire

// ==== bench/exec_unit_tb.sv ====
`default_nettype none
`include "alu_cfg.svh"

module exec_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import alu_pkg::*;

	localparam int N_DIRECTED = 32;
	localparam int N_RANDOM = 300;
	localparam int TIMEOUT = (N_DIRECTED + N_RANDOM) * 36 + 200;	// div is the longest op

	logic clk, reset, start, branch_taken, busy, done;
	alu_op_e op;
	logic [`XLEN-1:0] a, b, result;
	integer seed = 32'h13f59020;
	int cycles = 0;
	int cyc_left;	// cycles until the expected done, 0 when idle
	logic [`XLEN-1:0] exp_res;
	logic exp_br;

	exec_unit u_exec_unit (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.result(result),
		.branch_taken(branch_taken),
		.busy(busy),
		.done(done)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////
	// reference model

	function automatic logic [`XLEN-1:0] model_result(alu_op_e o, logic [31:0] x, logic [31:0] y);
		logic signed [63:0] sx, sy, ux, uy;
		logic signed [31:0] xs;
		logic [63:0] p;
		logic ovf;
		sx = {{32{x[31]}}, x};
		sy = {{32{y[31]}}, y};
		ux = {32'h0, x};
		uy = {32'h0, y};
		xs = x;
		ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
		case (o)
			ADD: return x + y;
			SUB, BEQ, BNE, BLT, BGE, BLTU, BGEU: return x - y;
			SLL: return x << y[4:0];
			SRL: return x >> y[4:0];
			SRA: return xs >>> y[4:0];
			OR: return x | y;
			AND: return x & y;
			XOR: return x ^ y;
			SLT: return {31'b0, $signed(x) < $signed(y)};
			SLTU: return {31'b0, x < y};
			MUL, MULH: begin
				p = sx * sy;
				return (o == MUL) ? p[31:0] : p[63:32];
			end
			MULHSU: begin
				p = sx * uy;	// a signed, b unsigned
				return p[63:32];
			end
			MULHU: begin
				p = ux * uy;
				return p[63:32];
			end
			DIV: begin
				if (y == 0)
					return '1;
				if (ovf)
					return x;
				return $signed(x) / $signed(y);
			end
			DIVU: return (y == 0) ? '1 : x / y;
			REM: begin
				if (y == 0)
					return x;
				if (ovf)
					return '0;
				return $signed(x) % $signed(y);
			end
			REMU: return (y == 0) ? x : x % y;
			default: return '0;
		endcase
	endfunction

	function automatic logic model_branch(alu_op_e o, logic [31:0] x, logic [31:0] y);
		case (o)
			BEQ: return x == y;
			BNE: return x != y;
			BLT: return $signed(x) < $signed(y);
			BGE: return $signed(x) >= $signed(y);
			BLTU: return x < y;
			BGEU: return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	function automatic int latency_of(alu_op_e o);
		if (o inside {MUL, MULH, MULHSU, MULHU})
			return 3;
		if (o inside {DIV, DIVU, REM, REMU})
			return 34;
		return 1;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			cyc_left <= 0;
			exp_res <= '0;
			exp_br <= 1'b0;
		end else if (start && cyc_left == 0) begin
			cyc_left <= latency_of(op);
			exp_res <= model_result(op, a, b);
			exp_br <= model_branch(op, a, b);
		end else if (cyc_left != 0) begin
			cyc_left <= cyc_left - 1;	// a start while busy is dropped
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////
	// checks

	a_busy: assert property (@(posedge clk) disable iff (reset) busy == (cyc_left != 0))
		else begin
			$display("error busy exp=%h got=%h", $sampled(cyc_left != 0), $sampled(busy));
			$display("Test failed");
			$fatal(1);
		end
	a_done: assert property (@(posedge clk) disable iff (reset) done == (cyc_left == 1))
		else begin
			$display("error done exp=%h got=%h", $sampled(cyc_left == 1), $sampled(done));
			$display("Test failed");
			$fatal(1);
		end
	a_result: assert property (@(posedge clk) disable iff (reset)
		cyc_left <= 1 |-> result == exp_res)
		else begin
			$display("error result exp=%h got=%h", $sampled(exp_res), $sampled(result));
			$display("Test failed");
			$fatal(1);
		end
	a_branch: assert property (@(posedge clk) disable iff (reset)
		cyc_left <= 1 |-> branch_taken == exp_br)
		else begin
			$display("error branch_taken exp=%h got=%h", $sampled(exp_br), $sampled(branch_taken));
			$display("Test failed");
			$fatal(1);
		end

	////////////////////////////////////////
	// stimulus

	task automatic run_op(input alu_op_e o, input logic [31:0] x, input logic [31:0] y,
		input int poke_at);
		int n;
		@(negedge clk);
		start = 1'b1;
		op = o;
		a = x;
		b = y;
		@(negedge clk);
		start = 1'b0;
		n = 1;
		while (!done) begin
			if (n == poke_at) begin
				start = 1'b1;	// extra start while busy, operands stay put
				op = ADD;
			end else begin
				start = 1'b0;
			end
			@(negedge clk);
			n++;
		end
		start = 1'b0;
	endtask

	task automatic pick_operand(output logic [31:0] v);
		logic [31:0] r;
		r = $random(seed);
		case (r[2:0])
			3'd0: v = '0;
			3'd1: v = '1;
			3'd2: v = 32'h8000_0000;
			default: v = $random(seed);
		endcase
	endtask

	task automatic random_ops(input int count);
		logic [31:0] r, x, y;
		for (int k = 0; k < count; k++) begin
			r = $random(seed);
			pick_operand(x);
			pick_operand(y);
			run_op(alu_op_e'(5'(r % 24)), x, y, 0);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		op = ADD;
		a = '0;
		b = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		repeat (3) @(negedge clk);	// quiet idle after reset

		run_op(ADD, 32'h7fff_ffff, 32'h0000_0001, 0);
		run_op(SUB, 32'h0000_0005, 32'h0000_0007, 0);
		run_op(SLL, 32'h8000_0001, 32'h0000_0021, 0);
		run_op(SRL, 32'hf000_0000, 32'h0000_0004, 0);
		run_op(SRA, 32'hf000_0000, 32'h0000_0004, 0);
		run_op(OR, 32'h1234_5678, 32'h0f0f_0f0f, 0);
		run_op(AND, 32'h1234_5678, 32'h0f0f_0f0f, 0);
		run_op(XOR, 32'h1234_5678, 32'h0f0f_0f0f, 0);
		run_op(SLT, 32'hffff_ffff, 32'h0000_0001, 0);
		run_op(SLTU, 32'hffff_ffff, 32'h0000_0001, 0);
		run_op(BEQ, 32'h0000_0005, 32'h0000_0005, 0);
		run_op(BNE, 32'h0000_0005, 32'h0000_0005, 0);
		run_op(BLT, 32'hffff_ffff, 32'h0000_0001, 0);
		run_op(BGE, 32'hffff_ffff, 32'h0000_0001, 0);
		run_op(BLTU, 32'hffff_ffff, 32'h0000_0001, 0);
		run_op(BGEU, 32'hffff_ffff, 32'h0000_0001, 0);

		run_op(MUL, 32'hffff_fffe, 32'h0000_0003, 0);
		run_op(MULH, 32'h8000_0000, 32'h8000_0000, 0);
		run_op(MULHSU, 32'hffff_ffff, 32'hffff_ffff, 0);
		run_op(MULHU, 32'hffff_ffff, 32'hffff_ffff, 0);

		run_op(DIV, 32'hffff_fff9, 32'h0000_0002, 0);
		run_op(DIVU, 32'hffff_fff9, 32'h0000_0002, 0);
		run_op(REM, 32'hffff_fff9, 32'h0000_0002, 0);
		run_op(REMU, 32'hffff_fff9, 32'h0000_0002, 0);
		run_op(DIV, 32'h1234_5678, 32'h0000_0000, 0);	// divide by zero
		run_op(DIVU, 32'h1234_5678, 32'h0000_0000, 0);
		run_op(REM, 32'h8765_4321, 32'h0000_0000, 0);
		run_op(REMU, 32'h8765_4321, 32'h0000_0000, 0);
		run_op(DIV, 32'h8000_0000, 32'hffff_ffff, 0);	// signed overflow
		run_op(REM, 32'h8000_0000, 32'hffff_ffff, 0);

		run_op(DIV, 32'h0000_0064, 32'h0000_0007, 5);
		run_op(MUL, 32'h0001_0001, 32'h0000_ffff, 1);

		random_ops(N_RANDOM);
		repeat (3) @(negedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/alu_pkg.sv
design/alu_step_if.sv
design/alu_sequencer.sv
design/step_counter.sv
design/long_div.sv
design/mul_pipe.sv
design/barrel_shifter.sv
design/alu_core.sv
design/exec_unit.sv
bench/exec_unit_tb.sv
